// File: memBusPkg.sv
package memBusPkg;

    // Address map.
    localparam logic [31:0] periphBase = 32'h4000_0000;
    localparam logic [31:0] periphMask = 32'hFFFF_FF00; // Window 0x400000xx.

    localparam logic [31:0] thAddr     = 32'h0000_0000;
    localparam logic [31:0] tlAddr     = 32'h0000_0004;
    localparam logic [31:0] tconAddr   = 32'h0000_0008;
    localparam logic [31:0] ledAddr    = 32'h0000_000C;
    localparam logic [31:0] switchAddr = 32'h0000_0010;
    localparam logic [31:0] tubeAddr   = 32'h0000_0014;

    // Data RAM geometry.
    localparam int ramDepth    = 256;
    localparam int ramIndexLsb = 2;
    localparam int ramIndexMsb = 9;

    localparam int ledWidth     = 8;
    localparam int switchWidth  = 8;
    localparam int tubeRegWidth = 18;
    localparam int tubeOutWidth = 22;

    localparam logic [tubeRegWidth-1:0] tubeResetValue = 18'h3F87F;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } busReq_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } busRsp_t;

    // Register block to timer.
    typedef struct packed {
        logic        enable;    // TCON bit 0.
        logic        irqEnable; // TCON bit 1.
        logic [31:0] th;
        logic        loadTl;
        logic [31:0] tlValue;
        logic        clearIrq;
    } timerCtl_t;

    typedef struct packed {
        logic [31:0] tl;
        logic        irq;
    } timerState_t;

endpackage

// File: dataRam.sv
`timescale 1ns/1ps

module dataRam (
    input  logic               Uart_send_trigger,
    input  logic               clk,
    input  memBusPkg::busReq_t req,
    output memBusPkg::busRsp_t rsp
);
    import memBusPkg::*;

    logic [31:0] mem [ramDepth];
    logic [ramIndexMsb-ramIndexLsb:0] index;
    logic wrEn;
    logic rdEn;
    logic rspValid;
    logic [31:0] rspData;

    assign index = req.addr[ramIndexMsb:ramIndexLsb]; // Word index only.
    assign wrEn  = req.valid && req.write;
    assign rdEn  = req.valid && !req.write;

    // Array is cleared on reset.
    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < ramDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[index] <= req.wdata;
        end
    end

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= rdEn; // One cycle after acceptance.
        end
    end

    always_ff @(posedge Uart_send_trigger) begin
        if (rdEn) begin
            rspData <= mem[index];
        end
    end

    assign rsp = '{valid: rspValid, data: rspData};

endmodule

// File: peripheralRegs.sv
`timescale 1ns/1ps

module peripheralRegs (
    input  logic                                  Uart_send_trigger,
    input  logic                                  clk,
    input  memBusPkg::busReq_t                    req,
    input  logic [memBusPkg::switchWidth-1:0]     switch,
    input  memBusPkg::timerState_t                timerState,
    output memBusPkg::busRsp_t                    rsp,
    output logic [memBusPkg::ledWidth-1:0]        led,
    output logic [memBusPkg::tubeOutWidth-1:0]    tube,
    output memBusPkg::timerCtl_t                  timerCtl
);
    import memBusPkg::*;

    logic [31:0] offset;
    logic wrEn;
    logic rdEn;

    logic [ledWidth-1:0] ledReg;
    logic [tubeRegWidth-1:0] tubeReg;
    logic [31:0] thReg;
    logic enable;
    logic irqEnable;

    logic [31:0] readMux;
    logic rspValid;
    logic [31:0] rspData;

    assign offset = req.addr & ~periphMask;
    assign wrEn   = req.valid && req.write;
    assign rdEn   = req.valid && !req.write;

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            ledReg    <= '0;
            tubeReg   <= tubeResetValue;
            thReg     <= '0;
            enable    <= 1'b0;
            irqEnable <= 1'b0;
        end else if (wrEn) begin
            case (offset)
                ledAddr:  ledReg  <= req.wdata[ledWidth-1:0];
                tubeAddr: tubeReg <= req.wdata[tubeRegWidth-1:0];
                thAddr:   thReg   <= req.wdata;
                tconAddr: begin
                    enable    <= req.wdata[0];
                    irqEnable <= req.wdata[1];
                end
                default: ;
            endcase
        end
    end

    // TL lives in the timer, so its write is passed on as a strobe.
    assign timerCtl = '{
        enable:    enable,
        irqEnable: irqEnable,
        th:        thReg,
        loadTl:    wrEn && (offset == tlAddr),
        tlValue:   req.wdata,
        clearIrq:  wrEn && (offset == tconAddr)
    };

    always_comb begin
        case (offset)
            thAddr:     readMux = thReg;
            tlAddr:     readMux = timerState.tl;
            tconAddr:   readMux = {29'b0, timerState.irq, irqEnable, enable};
            switchAddr: readMux = {{(32-switchWidth){1'b0}}, switch};
            default:    readMux = '0; // Unmapped reads as zero.
        endcase
    end

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= rdEn;
        end
    end

    always_ff @(posedge Uart_send_trigger) begin
        if (rdEn) begin
            rspData <= readMux;
        end
    end

    assign rsp  = '{valid: rspValid, data: rspData};
    assign led  = ledReg;
    assign tube = {tubeReg[10:7], tubeReg}; // Digit select bits repeated on top.

endmodule

// File: intervalTimer.sv
`timescale 1ns/1ps

module intervalTimer (
    input  logic                   Uart_send_trigger,
    input  logic                   clk,
    input  memBusPkg::timerCtl_t   timerCtl,
    output memBusPkg::timerState_t timerState
);
    import memBusPkg::*;

    logic [31:0] tl;
    logic irq;
    logic atTop;
    logic counting;
    logic expire;

    // A TL write from the bus takes priority over counting.
    assign counting = timerCtl.enable && !timerCtl.loadTl;
    assign atTop    = (tl == '1);
    assign expire   = counting && atTop && timerCtl.irqEnable;

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            tl <= '0;
        end else if (timerCtl.loadTl) begin
            tl <= timerCtl.tlValue;
        end else if (counting) begin
            if (atTop) begin
                tl <= timerCtl.th; // Reload.
            end else begin
                tl <= tl + 32'd1;
            end
        end
    end

    // New expiry beats a clear in the same cycle.
    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            irq <= 1'b0;
        end else if (expire) begin
            irq <= 1'b1;
        end else if (timerCtl.clearIrq) begin
            irq <= 1'b0;
        end
    end

    assign timerState = '{tl: tl, irq: irq};

endmodule

// File: dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
    input  logic                               Uart_send_trigger,
    input  logic                               clk,
    input  memBusPkg::busReq_t                 req,
    input  logic [memBusPkg::switchWidth-1:0]  switch,
    output memBusPkg::busRsp_t                 rsp,
    output logic [memBusPkg::ledWidth-1:0]     led,
    output logic [memBusPkg::tubeOutWidth-1:0] tube,
    output logic                               ifContinue
);
    import memBusPkg::*;

    logic isPeriph;
    logic selPeriph;
    busReq_t ramReq;
    busReq_t periphReq;
    busRsp_t ramRsp;
    busRsp_t periphRsp;
    timerCtl_t timerCtl;
    timerState_t timerState;

    assign isPeriph = (req.addr & periphMask) == periphBase;

    // Each request goes to exactly one block.
    always_comb begin
        ramReq          = req;
        ramReq.valid    = req.valid && !isPeriph;
        periphReq       = req;
        periphReq.valid = req.valid && isPeriph;
    end

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            selPeriph <= 1'b0;
        end else begin
            selPeriph <= req.valid && !req.write && isPeriph; // Region of this read.
        end
    end

    assign rsp = selPeriph ? periphRsp : ramRsp;

    dataRam dataRam_inst (
        .Uart_send_trigger(Uart_send_trigger),
        .clk(clk),
        .req(ramReq),
        .rsp(ramRsp)
    );

    peripheralRegs peripheralRegs_inst (
        .Uart_send_trigger(Uart_send_trigger),
        .clk(clk),
        .req(periphReq),
        .switch(switch),
        .timerState(timerState),
        .rsp(periphRsp),
        .led(led),
        .tube(tube),
        .timerCtl(timerCtl)
    );

    intervalTimer intervalTimer_inst (
        .Uart_send_trigger(Uart_send_trigger),
        .clk(clk),
        .timerCtl(timerCtl),
        .timerState(timerState)
    );

    assign ifContinue = timerState.irq;

endmodule

// File: dataMemoryTb.sv
`timescale 1ns/1ps

module dataMemoryTb;
    import memBusPkg::*;

    localparam int maxCycles = 5000; // The full run needs a few hundred cycles.
    localparam int ramWrites = 40;

    logic Uart_send_trigger;
    logic clk;
    busReq_t req;
    logic [switchWidth-1:0] switch;
    busRsp_t rsp;
    logic [ledWidth-1:0] led;
    logic [tubeOutWidth-1:0] tube;
    logic ifContinue;

    logic [31:0] rngState = 32'h9b7b;
    logic [31:0] ramModel [ramDepth];
    logic [31:0] wrAddr [ramWrites];
    int cycleCount = 0;

    dataMemory dataMemory_inst (
        .Uart_send_trigger(Uart_send_trigger),
        .clk(clk),
        .req(req),
        .switch(switch),
        .rsp(rsp),
        .led(led),
        .tube(tube),
        .ifContinue(ifContinue)
    );

    initial begin
        Uart_send_trigger = 1'b0;
        forever #10 Uart_send_trigger = ~Uart_send_trigger;
    end

    always @(posedge Uart_send_trigger) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic reportError(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Every accepted read gets exactly one response, one cycle later.
    assert property (@(posedge Uart_send_trigger) disable iff (clk)
        rsp.valid == $past(req.valid && !req.write))
        else reportError("rsp.valid does not follow an accepted read by one cycle");

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // Display output carries bits 10..7 again on top.
    function automatic logic [tubeOutWidth-1:0] extendTube(
        input logic [tubeRegWidth-1:0] value
    );
        return {value[10:7], value};
    endfunction

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got === exp)
            else reportError($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    // All bus tasks start and end just after a falling edge.
    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        req = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge Uart_send_trigger);
        @(negedge Uart_send_trigger);
        req.valid = 1'b0;
    endtask

    task automatic readWord(input logic [31:0] addr, output logic [31:0] data);
        req = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
        @(posedge Uart_send_trigger);
        @(negedge Uart_send_trigger);
        req.valid = 1'b0;
        assert (rsp.valid) else reportError("no response to a read");
        data = rsp.data;
    endtask

    task automatic pairedRead(input logic [31:0] addrA, input logic [31:0] addrB,
                              output logic [31:0] dataA, output logic [31:0] dataB);
        req = '{valid: 1'b1, write: 1'b0, addr: addrA, wdata: 32'h0};
        @(posedge Uart_send_trigger);
        @(negedge Uart_send_trigger);
        assert (rsp.valid) else reportError("no response to first read of a pair");
        dataA = rsp.data;
        req.addr = addrB; // Second read issued while the first answer is out.
        @(posedge Uart_send_trigger);
        @(negedge Uart_send_trigger);
        req.valid = 1'b0;
        assert (rsp.valid) else reportError("no response to second read of a pair");
        dataB = rsp.data;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(negedge Uart_send_trigger);
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [31:0] rdata2;
        logic [31:0] tlFirst;
        logic [31:0] elapsed;
        int waited;

        clk = 1'b1;
        req = '0;
        switch = 8'hA5;
        ramModel = '{default: '0};
        repeat (5) @(posedge Uart_send_trigger);
        @(negedge Uart_send_trigger);
        clk = 1'b0;

        // State after reset.
        checkValue(32'(led), 32'h0, "led after reset");
        assert (tube == extendTube(tubeResetValue))
            else reportError($sformatf("tube after reset: got %h", tube));
        assert (!ifContinue) else reportError("ifContinue high after reset");
        for (int i = 0; i < 3; i++) begin
            addr = nextRand() & 32'h0FFF_FFFC;
            readWord(addr, rdata);
            checkValue(rdata, 32'h0, "RAM after reset");
        end
        readWord(periphBase | tconAddr, rdata);
        checkValue(rdata, 32'h0, "TCON after reset");

        // RAM writes with aliased and repeated word indices.
        for (int i = 0; i < ramWrites; i++) begin
            if (i % 8 == 7) begin
                addr = wrAddr[i-1] ^ 32'h0000_4000; // Same index, other alias.
            end else begin
                addr = nextRand() & 32'h0FFF_F0FC; // Only 64 indices.
            end
            data = nextRand();
            wrAddr[i] = addr;
            ramModel[addr[9:2]] = data;
            writeWord(addr, data);
        end
        for (int i = 0; i < ramWrites; i += 2) begin
            pairedRead(wrAddr[i], wrAddr[i+1], rdata, rdata2);
            checkValue(rdata, ramModel[wrAddr[i][9:2]], "RAM readback");
            checkValue(rdata2, ramModel[wrAddr[i+1][9:2]], "RAM readback");
        end

        // LED, tube, switches and an unmapped offset.
        writeWord(periphBase | ledAddr, 32'h0000_005A);
        checkValue(32'(led), 32'h0000_005A, "led");
        writeWord(periphBase | tubeAddr, 32'h0002_B3C5);
        assert (tube == extendTube(18'h2B3C5))
            else reportError($sformatf("tube after write: got %h", tube));
        readWord(periphBase | switchAddr, rdata);
        checkValue(rdata, 32'h0000_00A5, "switch read");
        switch = 8'h3C;
        readWord(periphBase | switchAddr, rdata);
        checkValue(rdata, 32'h0000_003C, "switch read");
        readWord(periphBase | 32'h0000_0018, rdata);
        checkValue(rdata, 32'h0, "unmapped offset");

        // Timer expiry with interrupt.
        writeWord(periphBase | thAddr, 32'd100);
        readWord(periphBase | thAddr, rdata);
        checkValue(rdata, 32'd100, "TH readback");
        writeWord(periphBase | tlAddr, 32'hFFFF_FFF6);
        writeWord(periphBase | tconAddr, 32'h0000_0003);
        waited = 0;
        while (!ifContinue && waited < 20) begin
            @(negedge Uart_send_trigger);
            waited++;
        end
        assert (ifContinue) else reportError("ifContinue did not rise within 20 cycles");
        idleCycles(5);
        elapsed = 32'd6; // Five idle cycles plus the read itself.
        readWord(periphBase | tlAddr, rdata);
        assert (rdata >= 32'd100 && rdata <= 32'd100 + elapsed)
            else reportError($sformatf("TL after reload out of range: %0d", rdata));
        readWord(periphBase | tconAddr, rdata);
        checkValue(rdata, 32'h0000_0007, "TCON with irq");

        // Clear, hold, then wrap with interrupts off.
        writeWord(periphBase | tconAddr, 32'h0);
        assert (!ifContinue) else reportError("ifContinue still high after TCON write");
        readWord(periphBase | tlAddr, tlFirst);
        idleCycles(10);
        readWord(periphBase | tlAddr, rdata);
        checkValue(rdata, tlFirst, "TL while disabled");
        writeWord(periphBase | tlAddr, 32'hFFFF_FFFC);
        writeWord(periphBase | tconAddr, 32'h0000_0001);
        for (int i = 0; i < 12; i++) begin
            @(negedge Uart_send_trigger);
            assert (!ifContinue) else reportError("ifContinue rose with irqEnable low");
        end
        readWord(periphBase | tlAddr, rdata);
        assert (rdata >= 32'd100 && rdata < 32'd116)
            else reportError($sformatf("TL did not wrap to TH: %h", rdata));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: src.f
memBusPkg.sv
dataRam.sv
peripheralRegs.sv
intervalTimer.sv
dataMemory.sv
dataMemoryTb.sv

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module dataMemoryTb -o simDataMemory

# The simulator exit status is lost in the pipe, so the log decides.
./obj_dir/simDataMemory | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
